// ==== vlog.f ====
design/cpuControlPkg.sv
design/irqGate.sv
design/statusFlags.sv
design/cycleSequencer.sv
design/controlDecoder.sv
design/cpuControl.sv
bench/clockGen.sv
bench/cpuControlTb.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpuControlTb -f vlog.f -o cpuControlSim
./obj_dir/cpuControlSim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
grep -q "STATUS: PASS" sim.log

// ==== bench/cpuControlTb.sv ====
// Testbench driving random instruction streams into the control unit against a cycle model
`timescale 1ns/10ps

module cpuControlTb import cpuControlPkg::*; ();

	logic Clock;
	logic nReset;
	logic [7:0] OpcodeCondIn;
	logic [StatusWidth-1:0] Flags;
	logic nIRQ;
	logic nWait;
	logic AluEn;
	logic AluWe;
	logic PcEn;
	logic PcWe;
	logic RegWe;
	logic IrWe;
	pcSelT PcSel;
	op1SelT Op1Sel;
	op2SelT Op2Sel;
	immSelT ImmSel;
	rs1SelT Rs1Sel;
	rwSelT RwSel;
	wdSelT WdSel;
	aluOrT AluOr;
	logic Ale;
	logic nMe;
	logic nOe;
	logic nWe;
	logic MemEn;
	logic Enb;
	logic [StatusWidth-1:0] StatusReg;
	logic CFlag;

	// Cycle model of sequencer, synchroniser, enable flag and status register
	majorStateT modelState;
	subCycleT modelSub;
	logic modelMeta;
	logic modelSync;
	logic modelEn;
	logic [StatusWidth-1:0] modelStatus;
	opcodeT curOp;
	branchT curCond;
	int seed = 32'h5fc4;
	int irqMode;
	int waitRun;
	int dutEntries;

	clockGen clockGen_inst (
		.Clock(Clock),
		.nReset(nReset)
	);

	cpuControl cpuControl_inst (.*);

	task automatic abortRun();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
			abortRun();
		end
	endtask

	function automatic int randBelow(input int n);
		int unsigned r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic bit isAluOp(input opcodeT op);
		case (op)
			ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG,
			CMP, CMPI, AND, OR, XOR, NAND, NOR, NOT, LSL, LSR, ASR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic bit twoRegOp(input opcodeT op);
		case (op)
			ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic bit condHolds(input branchT code, input logic [StatusWidth-1:0] s);
		case (code)
			BR, JMP: return 1'b1;
			BNE: return !s[FlagZ];
			BE: return s[FlagZ];
			BLT: return s[FlagN] != s[FlagV];
			BGE: return s[FlagN] == s[FlagV];
			default: return 1'b0;
		endcase
	endfunction

	function automatic subCycleT nextSubCycle(input subCycleT s);
		case (s)
			cycle4: return cycle0;
			cycle0: return cycle1;
			cycle1: return cycle2;
			cycle2: return cycle3;
			default: return cycle0;
		endcase
	endfunction

	task automatic checkOutputs();
		logic wantAle;
		logic wantNMe;
		logic wantNWe;
		logic wantIrWe;
		logic wantPcWe;
		logic wantRegWe;
		logic aluCycle;
		pcSelT wantPcSel;
		wdSelT wantWdSel;
		wantAle = 1'b0;
		wantNMe = 1'b1;
		wantNWe = 1'b1;
		wantIrWe = 1'b0;
		wantPcWe = 1'b0;
		wantRegWe = 1'b0;
		aluCycle = 1'b0;
		wantPcSel = Pc1;
		wantWdSel = WdAlu;
		case (modelState)
			fetch: begin
				wantAle = (modelSub == cycle0);
				wantNMe = !(modelSub == cycle1 || modelSub == cycle2);
				// IR loads only when the read completes
				if (modelSub == cycle2)
					wantIrWe = nWait;
			end
			execute: begin
				if (modelSub == cycle4) begin
					if (isAluOp(curOp)) begin
						aluCycle = 1'b1;
						wantPcWe = 1'b1;
						wantRegWe = (curOp != CMP) && (curOp != CMPI);
					end else if (curOp == BRANCH) begin
						wantPcWe = 1'b1;
						wantPcSel = condHolds(curCond, modelStatus) ? PcAluOut : Pc1;
					end else if (curOp == INTCTL) begin
						wantPcWe = 1'b1;
					end
				end else begin
					// Data memory cycle of LDW or STW
					wantAle = (modelSub == cycle0);
					wantNMe = !(modelSub == cycle1 || modelSub == cycle2);
					wantNWe = !(modelSub == cycle3 && curOp == STW);
					if (modelSub == cycle2) begin
						wantPcWe = nWait;
						if (curOp == LDW) begin
							wantRegWe = nWait;
							wantWdSel = WdSys;
						end
					end
				end
			end
			interrupt: begin
				wantAle = (modelSub == cycle0);
				wantNMe = !(modelSub == cycle1 || modelSub == cycle2);
				wantNWe = (modelSub != cycle3);
				// Stack pointer drop first and vector load last
				wantRegWe = (modelSub == cycle4);
				if (modelSub == cycle3) begin
					wantPcWe = 1'b1;
					wantPcSel = PcInt;
				end
			end
			default: begin
			end
		endcase
		checkValue("Ale", 32'(Ale), 32'(wantAle));
		checkValue("nMe", 32'(nMe), 32'(wantNMe));
		checkValue("nWe", 32'(nWe), 32'(wantNWe));
		checkValue("IrWe", 32'(IrWe), 32'(wantIrWe));
		checkValue("PcWe", 32'(PcWe), 32'(wantPcWe));
		checkValue("RegWe", 32'(RegWe), 32'(wantRegWe));
		if (wantPcWe)
			checkValue("PcSel", 32'(PcSel), 32'(wantPcSel));
		if (wantRegWe)
			checkValue("WdSel", 32'(WdSel), 32'(wantWdSel));
		if (modelState == fetch) begin
			checkValue("AluEn", 32'(AluEn), 32'd0);
			checkValue("AluWe", 32'(AluWe), 32'd0);
		end
		if (modelState == fetch && modelSub == cycle0) begin
			// Address phase only
			checkValue("PcEn", 32'(PcEn), 32'd1);
			checkValue("nOe", 32'(nOe), 32'd1);
			checkValue("MemEn", 32'(MemEn), 32'd0);
			checkValue("Enb", 32'(Enb), 32'd0);
		end
		if (aluCycle) begin
			checkValue("PcEn", 32'(PcEn), 32'd1);
			checkValue("Op1Sel", 32'(Op1Sel), 32'(Op1Rd1));
			checkValue("Op2Sel", 32'(Op2Sel), 32'(twoRegOp(curOp) ? Op2Rd2 : Op2Imm));
			if (curOp inside {ADDI, ADCI, SUBI, SUCI, CMPI})
				checkValue("ImmSel", 32'(ImmSel), 32'(ImmShort));
		end
		if (modelState == execute && modelSub == cycle4 && curOp == BRANCH)
			checkValue("AluEn", 32'(AluEn), 32'd1);
		if (modelState == interrupt && modelSub == cycle4) begin
			checkValue("Rs1Sel", 32'(Rs1Sel), 32'(Rs1Sp));
			checkValue("RwSel", 32'(RwSel), 32'(RwSp));
			checkValue("AluOr", 32'(AluOr), 32'(SubOr));
		end
		checkValue("StatusReg", 32'(StatusReg), 32'(modelStatus));
		checkValue("CFlag", 32'(CFlag), 32'(modelStatus[FlagC]));
	endtask

	// Advance the model over the edge that ends the current cycle
	task automatic updateModel();
		logic intReq;
		logic memOp;
		logic statusWe;
		logic intOn;
		logic intOff;
		logic lastExec;
		majorStateT nextState;
		subCycleT nextSub;
		intReq = modelSync & modelEn;
		memOp = (curOp == LDW) || (curOp == STW);
		lastExec = (modelState == execute) && (modelSub == cycle4);
		statusWe = lastExec && isAluOp(curOp);
		intOn = lastExec && (curOp == INTCTL) && (curCond == INTEN);
		intOff = (lastExec && (curOp == INTCTL) && (curCond == INTDIS)) ||
			(modelState == interrupt && modelSub == cycle4);
		nextState = modelState;
		nextSub = nextSubCycle(modelSub);
		case (modelState)
			fetch: begin
				if (modelSub == cycle2 && !nWait) begin
					nextSub = cycle2;
				end else if (modelSub == cycle3) begin
					nextState = execute;
					nextSub = cycle4;
				end
			end
			execute: begin
				if (modelSub == cycle2 && !nWait) begin
					nextSub = cycle2;
				end else if (modelSub == cycle3 || (modelSub == cycle4 && !memOp)) begin
					nextState = intReq ? interrupt : fetch;
					nextSub = intReq ? cycle4 : cycle0;
				end
			end
			default: begin
				if (modelSub == cycle3) begin
					nextState = fetch;
					nextSub = cycle0;
				end
			end
		endcase
		modelSync = modelMeta;
		modelMeta = !nIRQ;
		if (intOff)
			modelEn = 1'b0;
		else if (intOn)
			modelEn = 1'b1;
		if (statusWe)
			modelStatus = Flags;
		modelState = nextState;
		modelSub = nextSub;
	endtask

	// One clock cycle entered 1 ns after a rising edge
	task automatic stepCycle();
		// Wait runs capped at three cycles
		if (waitRun < 3 && randBelow(4) == 0) begin
			nWait = 1'b0;
			waitRun++;
		end else begin
			nWait = 1'b1;
			waitRun = 0;
		end
		Flags = StatusWidth'(randBelow(16));
		case (irqMode)
			0: nIRQ = (randBelow(6) != 0);
			1: nIRQ = 1'b0;
			default: nIRQ = 1'b1;
		endcase
		#4;
		checkOutputs();
		// Vector load marks the last cycle of an interrupt entry
		if (PcWe && PcSel == PcInt)
			dutEntries++;
		@(posedge Clock);
		updateModel();
		#1;
	endtask

	task automatic runInstruction(input opcodeT op, input branchT cond);
		int cycles;
		curOp = op;
		curCond = cond;
		OpcodeCondIn = {op, cond};
		cycles = 0;
		do begin
			stepCycle();
			cycles++;
			if (cycles > 40) begin
				$display("Instruction %s did not return to fetch within 40 cycles", op.name());
				abortRun();
			end
		end while (!(modelState == fetch && modelSub == cycle0));
	endtask

	task automatic runRandom(input bit allowIntCtl);
		opcodeT op;
		branchT cond;
		op = opcodeT'(5'(randBelow(allowIntCtl ? 26 : 25)));
		if (op == BRANCH)
			cond = branchT'(3'(randBelow(6)));
		else if (op == INTCTL)
			cond = (randBelow(2) == 0) ? INTEN : INTDIS;
		else
			cond = branchT'(3'(randBelow(8)));
		runInstruction(op, cond);
	endtask

	task automatic waitForEntry(input int target, input int limit);
		int count;
		count = 0;
		while (dutEntries < target) begin
			runRandom(1'b0);
			count++;
			if (count > limit) begin
				$display("No interrupt entry after %0d instructions with a request held", limit);
				abortRun();
			end
		end
	endtask

	initial begin
		int timeout;
		int entriesBefore;
		OpcodeCondIn = {ADD, BR};
		Flags = '0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		modelState = fetch;
		modelSub = cycle0;
		modelMeta = 1'b0;
		modelSync = 1'b0;
		modelEn = 1'b0;
		modelStatus = '0;
		curOp = ADD;
		curCond = BR;
		irqMode = 2;
		waitRun = 0;
		dutEntries = 0;
		timeout = 0;
		while (nReset !== 1'b1) begin
			@(negedge Clock);
			timeout++;
			if (timeout > 20) begin
				$display("Reset was not released within 20 cycles");
				abortRun();
			end
		end
		// First cycle after reset is fetch sub-cycle 0
		checkOutputs();
		@(posedge Clock);
		updateModel();
		#1;

		// Request pulses ignored while interrupts are masked
		irqMode = 0;
		runInstruction(INTCTL, INTDIS);
		repeat (40) runRandom(1'b0);
		checkValue("interrupt entries", 32'(dutEntries), 32'd0);

		// Flag setting ALU ops followed by conditional branches on the result
		repeat (60) begin
			runInstruction(opcodeT'(5'(randBelow(22))), branchT'(3'(randBelow(8))));
			runInstruction(BRANCH, branchT'(3'(randBelow(6))));
		end

		// Full mix with enable toggling and random requests
		repeat (150) runRandom(1'b1);

		// One entry per INTEN under a held request
		irqMode = 2;
		runInstruction(INTCTL, INTDIS);
		irqMode = 1;
		entriesBefore = dutEntries;
		runInstruction(INTCTL, INTEN);
		waitForEntry(entriesBefore + 1, 10);
		repeat (8) runRandom(1'b0);
		checkValue("interrupt entries", 32'(dutEntries), 32'(entriesBefore + 1));
		runInstruction(INTCTL, INTEN);
		waitForEntry(entriesBefore + 2, 10);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== bench/clockGen.sv ====
// Testbench clock and power-on reset source for the control unit
`timescale 1ns/10ps

module clockGen (
	output logic Clock,
	output logic nReset
);

	// 10 ns period
	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// Held for four rising edges, released just after the last one
	initial begin
		nReset = 1'b0;
		repeat (4) @(posedge Clock);
		#1;
		nReset = 1'b1;
	end

endmodule

// ==== design/cpuControl.sv ====
// Processor control unit top joining sequencer, decoder, status and interrupt logic
`timescale 1ns/10ps

module cpuControl import cpuControlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic [7:0] OpcodeCondIn,
	input logic [StatusWidth-1:0] Flags,
	input logic nIRQ,
	input logic nWait,
	output logic AluEn,
	output logic AluWe,
	output logic PcEn,
	output logic PcWe,
	output logic RegWe,
	output logic IrWe,
	output pcSelT PcSel,
	output op1SelT Op1Sel,
	output op2SelT Op2Sel,
	output immSelT ImmSel,
	output rs1SelT Rs1Sel,
	output rwSelT RwSel,
	output wdSelT WdSel,
	output aluOrT AluOr,
	output logic Ale,
	output logic nMe,
	output logic nOe,
	output logic nWe,
	output logic MemEn,
	output logic Enb,
	output logic [StatusWidth-1:0] StatusReg,
	output logic CFlag
);

	majorStateT state;
	subCycleT subCycle;
	dpControlT control;
	busStrobeT strobes;
	branchT branchCode;
	logic memOp;
	logic intReq;
	logic intEnable;
	logic intDisable;
	logic statusWe;
	logic condTrue;

	assign branchCode = branchT'(OpcodeCondIn[2:0]);

	irqGate irqGate_inst (
		.Clock(Clock),
		.nReset(nReset),
		.nIRQ(nIRQ),
		.IntEnable(intEnable),
		.IntDisable(intDisable),
		.IntReq(intReq)
	);

	statusFlags statusFlags_inst (
		.Clock(Clock),
		.nReset(nReset),
		.Flags(Flags),
		.StatusWe(statusWe),
		.BranchCode(branchCode),
		.StatusReg(StatusReg),
		.CFlag(CFlag),
		.CondTrue(condTrue)
	);

	cycleSequencer cycleSequencer_inst (
		.Clock(Clock),
		.nReset(nReset),
		.nWait(nWait),
		.MemOp(memOp),
		.IntReq(intReq),
		.State(state),
		.SubCycle(subCycle)
	);

	controlDecoder controlDecoder_inst (
		.State(state),
		.SubCycle(subCycle),
		.OpcodeCondIn(OpcodeCondIn),
		.nWait(nWait),
		.CondTrue(condTrue),
		.Control(control),
		.Strobes(strobes),
		.MemOp(memOp),
		.StatusWe(statusWe),
		.IntEnable(intEnable),
		.IntDisable(intDisable)
	);

	// Datapath controls out as separate pins
	assign AluEn = control.AluEn;
	assign AluWe = control.AluWe;
	assign PcEn = control.PcEn;
	assign PcWe = control.PcWe;
	assign RegWe = control.RegWe;
	assign IrWe = control.IrWe;
	assign PcSel = control.PcSel;
	assign Op1Sel = control.Op1Sel;
	assign Op2Sel = control.Op2Sel;
	assign ImmSel = control.ImmSel;
	assign Rs1Sel = control.Rs1Sel;
	assign RwSel = control.RwSel;
	assign WdSel = control.WdSel;
	assign AluOr = control.AluOr;

	// Bus strobes
	assign Ale = strobes.Ale;
	assign nMe = strobes.nMe;
	assign nOe = strobes.nOe;
	assign nWe = strobes.nWe;
	assign MemEn = strobes.MemEn;
	assign Enb = strobes.Enb;

endmodule

// ==== design/controlDecoder.sv ====
// Control decoder mapping state, sub-cycle and instruction onto every control line
`timescale 1ns/10ps

module controlDecoder import cpuControlPkg::*; (
	input majorStateT State,
	input subCycleT SubCycle,
	input logic [7:0] OpcodeCondIn,
	input logic nWait,
	input logic CondTrue,
	output dpControlT Control,
	output busStrobeT Strobes,
	output logic MemOp,
	output logic StatusWe,
	output logic IntEnable,
	output logic IntDisable
);

	opcodeT opcode;
	branchT branchCode;

	assign opcode = opcodeT'(OpcodeCondIn[7:3]);
	assign branchCode = branchT'(OpcodeCondIn[2:0]);

	// Loads and stores are the only data memory users
	assign MemOp = (opcode == LDW) || (opcode == STW);

	always_comb begin
		// Enables low, selects at their idle encodings
		Control = '0;
		Strobes = '{Ale: 1'b0, nMe: 1'b1, nOe: 1'b1, nWe: 1'b1, MemEn: 1'b0, Enb: 1'b0};
		StatusWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		case (State)
			fetch: begin
				case (SubCycle)
					cycle0: begin
						Strobes.Ale = 1'b1;
						Control.PcEn = 1'b1;
					end
					cycle1: begin
						Strobes.nMe = 1'b0;
						Strobes.MemEn = 1'b1;
						Control.PcEn = 1'b1;
					end
					cycle2: begin
						Strobes.nMe = 1'b0;
						Strobes.nOe = 1'b0;
						Strobes.MemEn = 1'b1;
						Strobes.Enb = 1'b1;
						// IR captures on the edge that ends the wait
						Control.IrWe = nWait;
					end
					cycle3: Control.PcEn = 1'b1;
					default: begin
					end
				endcase
			end
			execute: begin
				case (SubCycle)
					cycle4: begin
						case (opcode)
							ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG,
							CMP, CMPI, AND, OR, XOR, NAND, NOR, NOT, LSL, LSR, ASR: begin
								Control.PcEn = 1'b1;
								Control.PcWe = 1'b1;
								Control.PcSel = Pc1;
								StatusWe = 1'b1;
								// Compares only touch the flags
								Control.RegWe = (opcode != CMP) && (opcode != CMPI);
								case (opcode)
									ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR:
										Control.Op2Sel = Op2Rd2;
									ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR:
										Control.ImmSel = ImmShort;
									ADDIB, SUBIB:
										Control.Rs1Sel = Rs1Rd;
									default: begin
									end
								endcase
							end
							LDW, STW: begin
								// Address add before the bus cycle
								Control.AluEn = 1'b1;
								Control.AluWe = 1'b1;
								Control.ImmSel = ImmShort;
							end
							BRANCH: begin
								Control.AluEn = 1'b1;
								Control.PcWe = 1'b1;
								if (branchCode == JMP) begin
									Control.ImmSel = ImmShort;
									Control.Op1Sel = Op1Rd1;
								end else begin
									Control.ImmSel = ImmLong;
									Control.Op1Sel = Op1Pc;
								end
								Control.PcSel = CondTrue ? PcAluOut : Pc1;
							end
							INTCTL: begin
								Control.PcEn = 1'b1;
								Control.PcWe = 1'b1;
								Control.PcSel = Pc1;
								IntEnable = (branchCode == INTEN);
								IntDisable = (branchCode == INTDIS);
							end
							default: begin
							end
						endcase
					end
					cycle0: begin
						if (MemOp) begin
							Strobes.Ale = 1'b1;
							Control.ImmSel = ImmShort;
							Control.AluEn = 1'b1;
						end
					end
					cycle1: begin
						if (MemOp) begin
							Strobes.nMe = 1'b0;
							Strobes.MemEn = (opcode == LDW);
							Control.Rs1Sel = Rs1Rd;
							Control.Op2Sel = Op2Zero;
							Control.AluEn = 1'b1;
							Control.AluWe = 1'b1;
						end
					end
					cycle2: begin
						Control.PcWe = nWait;
						Control.PcSel = Pc1;
						Strobes.nMe = 1'b0;
						if (opcode == LDW) begin
							Strobes.nOe = 1'b0;
							Strobes.MemEn = 1'b1;
							Strobes.Enb = 1'b1;
							Control.WdSel = WdSys;
							Control.RegWe = nWait;
						end else begin
							// Store data held on the bus
							Control.AluEn = 1'b1;
							Control.Op2Sel = Op2Zero;
						end
					end
					cycle3: begin
						if (opcode == STW) begin
							Strobes.nWe = 1'b0;
							Control.AluEn = 1'b1;
							Control.Op2Sel = Op2Zero;
						end else begin
							Control.PcEn = 1'b1;
						end
					end
					default: begin
					end
				endcase
			end
			interrupt: begin
				case (SubCycle)
					cycle4: begin
						// Drop the stack pointer and block nesting
						IntDisable = 1'b1;
						Control.Rs1Sel = Rs1Sp;
						Control.RwSel = RwSp;
						Control.AluOr = SubOr;
						Control.Op2Sel = Op2Zero;
						Control.AluEn = 1'b1;
						Control.AluWe = 1'b1;
						Control.RegWe = 1'b1;
					end
					cycle0: begin
						Strobes.Ale = 1'b1;
						Control.Rs1Sel = Rs1Sp;
						Control.AluOr = SubOr;
						Control.Op2Sel = Op2Zero;
						Control.AluEn = 1'b1;
					end
					cycle1: begin
						Strobes.nMe = 1'b0;
						Control.Op2Sel = Op2Zero;
						Control.AluEn = 1'b1;
					end
					cycle2: begin
						// PC onto the bus as store data
						Strobes.nMe = 1'b0;
						Control.PcEn = 1'b1;
					end
					cycle3: begin
						Strobes.nWe = 1'b0;
						Control.PcEn = 1'b1;
						Control.PcWe = 1'b1;
						Control.PcSel = PcInt;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== design/cycleSequencer.sv ====
// Cycle sequencer stepping fetch, execute and interrupt through their sub-cycles
`timescale 1ns/10ps

module cycleSequencer import cpuControlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic nWait,
	input logic MemOp,
	input logic IntReq,
	output majorStateT State,
	output subCycleT SubCycle
);

	majorStateT nextState;
	subCycleT nextSub;
	majorStateT exitState;
	subCycleT exitSub;

	// Where execute goes once the instruction is done
	assign exitState = IntReq ? interrupt : fetch;
	assign exitSub = IntReq ? cycle4 : cycle0;

	always_comb begin
		nextState = State;
		nextSub = SubCycle;
		case (State)
			fetch: begin
				case (SubCycle)
					cycle0: nextSub = cycle1;
					cycle1: nextSub = cycle2;
					// Read held here while the memory is slow
					cycle2: begin
						if (nWait)
							nextSub = cycle3;
					end
					cycle3: begin
						nextState = execute;
						nextSub = cycle4;
					end
					default: nextSub = cycle0;
				endcase
			end
			execute: begin
				case (SubCycle)
					cycle4: begin
						if (MemOp) begin
							nextSub = cycle0;
						end else begin
							nextState = exitState;
							nextSub = exitSub;
						end
					end
					cycle0: nextSub = cycle1;
					cycle1: nextSub = cycle2;
					cycle2: begin
						if (nWait)
							nextSub = cycle3;
					end
					cycle3: begin
						nextState = exitState;
						nextSub = exitSub;
					end
					default: nextSub = cycle0;
				endcase
			end
			interrupt: begin
				// Fixed length, no wait states on the stack write
				case (SubCycle)
					cycle4: nextSub = cycle0;
					cycle0: nextSub = cycle1;
					cycle1: nextSub = cycle2;
					cycle2: nextSub = cycle3;
					default: begin
						nextState = fetch;
						nextSub = cycle0;
					end
				endcase
			end
			default: begin
				nextState = fetch;
				nextSub = cycle0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			State <= fetch;
			SubCycle <= cycle0;
		end else begin
			State <= nextState;
			SubCycle <= nextSub;
		end
	end

endmodule

// ==== design/statusFlags.sv ====
// Status register holding the ALU flags and evaluating branch conditions
`timescale 1ns/10ps

module statusFlags import cpuControlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic [StatusWidth-1:0] Flags,
	input logic StatusWe,
	input branchT BranchCode,
	output logic [StatusWidth-1:0] StatusReg,
	output logic CFlag,
	output logic CondTrue
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			StatusReg <= '0;
		else if (StatusWe)
			StatusReg <= Flags;
	end

	assign CFlag = StatusReg[FlagC];

	// Signed compares look at N against V
	always_comb begin
		case (BranchCode)
			BR, JMP:
				CondTrue = 1'b1;
			BNE:
				CondTrue = ~StatusReg[FlagZ];
			BE:
				CondTrue = StatusReg[FlagZ];
			BLT:
				CondTrue = StatusReg[FlagN] ^ StatusReg[FlagV];
			BGE:
				CondTrue = ~(StatusReg[FlagN] ^ StatusReg[FlagV]);
			default:
				CondTrue = 1'b0;
		endcase
	end

endmodule

// ==== design/irqGate.sv ====
// Interrupt request gate that synchronises nIRQ and masks it with the enable flag
`timescale 1ns/10ps

module irqGate (
	input logic Clock,
	input logic nReset,
	input logic nIRQ,
	input logic IntEnable,
	input logic IntDisable,
	output logic IntReq
);

	logic irqMeta;
	logic irqSync;
	logic intEnabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqMeta <= 1'b0;
			irqSync <= 1'b0;
			intEnabled <= 1'b0;
		end else begin
			// Two stages before the request is used
			irqMeta <= ~nIRQ;
			irqSync <= irqMeta;
			// Disable wins if both arrive together
			if (IntDisable)
				intEnabled <= 1'b0;
			else if (IntEnable)
				intEnabled <= 1'b1;
		end
	end

	assign IntReq = irqSync & intEnabled;

endmodule

// ==== design/cpuControlPkg.sv ====
// Shared encodings and control bundles for the 16-bit processor control unit
package cpuControlPkg;

	// Status register layout
	localparam int StatusWidth = 4;
	localparam int FlagZ = 0;
	localparam int FlagC = 1;
	localparam int FlagV = 2;
	localparam int FlagN = 3;

	// Instruction opcode in the top five bits of OpcodeCondIn
	typedef enum logic [4:0] {
		ADD,
		ADDI,
		ADDIB,
		ADC,
		ADCI,
		SUB,
		SUBI,
		SUBIB,
		SUC,
		SUCI,
		NEG,
		CMP,
		CMPI,
		AND,
		OR,
		XOR,
		NAND,
		NOR,
		NOT,
		LSL,
		LSR,
		ASR,
		LDW,
		STW,
		BRANCH,
		INTCTL
	} opcodeT;

	// Condition field, low three bits
	typedef enum logic [2:0] {
		BR,
		BNE,
		BE,
		BLT,
		BGE,
		JMP
	} branchT;

	// INTCTL reuses the condition field as a sub-code
	localparam branchT INTEN = branchT'(3'd1);
	localparam branchT INTDIS = branchT'(3'd2);

	typedef enum logic [1:0] {fetch, execute, interrupt} majorStateT;
	typedef enum logic [2:0] {cycle0, cycle1, cycle2, cycle3, cycle4} subCycleT;

	// Datapath selects, zero encoding is the idle choice
	typedef enum logic [1:0] {Pc1, PcAluOut, PcInt} pcSelT;
	typedef enum logic {Op1Rd1, Op1Pc} op1SelT;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2SelT;
	typedef enum logic {ImmLong, ImmShort} immSelT;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1SelT;
	typedef enum logic {RwRd, RwSp} rwSelT;
	typedef enum logic {WdAlu, WdSys} wdSelT;
	typedef enum logic [1:0] {NoOr, AddOr, SubOr} aluOrT;

	typedef struct packed {
		logic AluEn;
		logic AluWe;
		logic PcEn;
		logic PcWe;
		logic RegWe;
		logic IrWe;
		pcSelT PcSel;
		op1SelT Op1Sel;
		op2SelT Op2Sel;
		immSelT ImmSel;
		rs1SelT Rs1Sel;
		rwSelT RwSel;
		wdSelT WdSel;
		aluOrT AluOr;
	} dpControlT;

	// Memory bus strobes, the n-prefixed ones are active low
	typedef struct packed {
		logic Ale;
		logic nMe;
		logic nOe;
		logic nWe;
		logic MemEn;
		logic Enb;
	} busStrobeT;

endpackage
